// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_rv_core
FLIST   = vlog.f
OBJ_DIR = obj_dir
LOG     = sim.log
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== core_pkg.sv ====
package core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                // signed compare
        ALU_PASS_B              // non-alu instructions
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

    typedef enum logic [1:0] {
        FWD_REG,                // register file value
        FWD_EX,                 // result now in execute
        FWD_WB                  // result now in writeback
    } fwd_sel_e;

endpackage

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module exec_unit import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  ex_valid_i,
    input  logic [`RV_XLEN-1:0]   ex_pc_i,
    input  logic [`RV_XLEN-1:0]   ex_a_i,
    input  logic [`RV_XLEN-1:0]   ex_b_i,
    input  logic [`RV_XLEN-1:0]   ex_imm_i,
    input  alu_op_e               ex_alu_op_i,
    input  logic                  ex_use_imm_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_i,
    input  logic                  ex_rd_en_i,
    input  br_kind_e              ex_br_kind_i,
    output logic                  redirect_o,
    output logic [`RV_XLEN-1:0]   redirect_pc_o,
    output logic [`RV_XLEN-1:0]   ex_result_o,
    output logic                  ex_fwd_en_o,
    output logic                  wb_valid_o,
    output logic [`RV_REG_AW-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]   wb_result_o
);

    logic [`RV_XLEN-1:0] opnd_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] link_pc;
    logic                taken;

    assign opnd_b = ex_use_imm_i ? ex_imm_i : ex_b_i;

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:    alu_out = ex_a_i + opnd_b;
            ALU_SUB:    alu_out = ex_a_i - opnd_b;
            ALU_AND:    alu_out = ex_a_i & opnd_b;
            ALU_OR:     alu_out = ex_a_i | opnd_b;
            ALU_XOR:    alu_out = ex_a_i ^ opnd_b;
            ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(ex_a_i) < $signed(opnd_b)};
            ALU_PASS_B: alu_out = opnd_b;
            default:    alu_out = '0;
        endcase
    end

    // branches compare the two register operands, never the immediate
    always_comb begin
        case (ex_br_kind_i)
            BR_BEQ:  taken = (ex_a_i == ex_b_i);
            BR_BNE:  taken = (ex_a_i != ex_b_i);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign link_pc       = ex_pc_i + `RV_XLEN'(4);
    assign redirect_o    = ex_valid_i && taken;
    assign redirect_pc_o = ex_pc_i + ex_imm_i;           // pc-relative target
    assign ex_result_o   = (ex_br_kind_i == BR_JAL) ? link_pc : alu_out;
    assign ex_fwd_en_o   = ex_valid_i && ex_rd_en_i && (ex_rd_i != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_fwd_en_o;                   // x0 writes never retire
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o     <= ex_rd_i;
        wb_result_o <= ex_result_o;
    end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module fetch_unit import isa_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                redirect_i,
    input  logic [`RV_XLEN-1:0] redirect_pc_i,
    input  logic [`RV_ILEN-1:0] inst_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output inst_u               id_inst_o,
    output logic [`RV_XLEN-1:0] id_pc_o,
    output logic                id_valid_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;

    assign pc_next = redirect_i ? redirect_pc_i : pc_q + `RV_XLEN'(4);
    assign pc_o    = pc_q;                      // rom answers in the same cycle

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= `RV_RESET_PC;
            id_valid_o <= 1'b0;
        end else begin
            pc_q       <= pc_next;
            id_valid_o <= !redirect_i;          // wrong-path word dropped
        end
    end

    always_ff @(posedge clk) begin
        id_inst_o <= inst_i;
        id_pc_o   <= pc_q;
    end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module inst_decoder import isa_pkg::*, core_pkg::*; (
    input  inst_u                 inst_i,
    output logic [`RV_REG_AW-1:0] rs1_o,
    output logic [`RV_REG_AW-1:0] rs2_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output logic [`RV_XLEN-1:0]   imm_o,
    output alu_op_e               alu_op_o,
    output logic                  use_imm_o,
    output logic                  rd_en_o,
    output br_kind_e              br_kind_o
);

    always_comb begin
        rs1_o     = inst_i.r.rs1;                // same position in every format
        rs2_o     = inst_i.r.rs2;
        rd_o      = inst_i.r.rd;
        imm_o     = '0;
        alu_op_o  = ALU_PASS_B;
        use_imm_o = 1'b0;
        rd_en_o   = 1'b0;
        br_kind_o = BR_NONE;
        case (inst_i.r.opcode)
            OPC_OP: begin
                rd_en_o = 1'b1;
                case ({inst_i.r.funct7, inst_i.r.funct3})
                    {F7_BASE, F3_ADD}: alu_op_o = ALU_ADD;
                    {F7_ALT,  F3_ADD}: alu_op_o = ALU_SUB;
                    {F7_BASE, F3_SLT}: alu_op_o = ALU_SLT;
                    {F7_BASE, F3_XOR}: alu_op_o = ALU_XOR;
                    {F7_BASE, F3_OR}:  alu_op_o = ALU_OR;
                    {F7_BASE, F3_AND}: alu_op_o = ALU_AND;
                    default:           rd_en_o  = 1'b0;  // shifts, sltu, m ext
                endcase
            end
            OPC_OP_IMM: begin
                imm_o     = {{(`RV_XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
                use_imm_o = 1'b1;
                rd_en_o   = 1'b1;
                case (inst_i.i.funct3)
                    F3_ADD:  alu_op_o = ALU_ADD;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    F3_AND:  alu_op_o = ALU_AND;
                    default: rd_en_o  = 1'b0;            // slti and shifts unsupported
                endcase
            end
            OPC_BRANCH: begin
                imm_o = {{(`RV_XLEN-13){inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                         inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
                case (inst_i.b.funct3)
                    F3_BEQ:  br_kind_o = BR_BEQ;
                    F3_BNE:  br_kind_o = BR_BNE;
                    default: br_kind_o = BR_NONE;        // blt/bge family
                endcase
            end
            OPC_JAL: begin
                imm_o     = {{(`RV_XLEN-21){inst_i.j.imm20}}, inst_i.j.imm20,
                             inst_i.j.imm19_12, inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
                rd_en_o   = 1'b1;                        // link register
                br_kind_o = BR_JAL;
            end
            default: ;                                   // executes as a nop
        endcase
    end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // register-register alu
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD = 3'b000,            // also sub with alt funct7
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } br_f3_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000        // selects sub
    } funct7_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one fetched word, read through whichever format the opcode names
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        j_fmt_t j;
    } inst_u;

endpackage

// ==== issue_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module issue_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  id_valid_i,
    input  logic [`RV_XLEN-1:0]   id_pc_i,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  logic [`RV_XLEN-1:0]   rs1_data_i,
    input  logic [`RV_XLEN-1:0]   rs2_data_i,
    input  logic [`RV_XLEN-1:0]   imm_i,
    input  alu_op_e               alu_op_i,
    input  logic                  use_imm_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic                  rd_en_i,
    input  br_kind_e              br_kind_i,
    input  logic                  flush_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_i,
    input  logic                  ex_rd_en_i,
    input  logic [`RV_XLEN-1:0]   ex_result_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_i,
    input  logic                  wb_rd_en_i,
    input  logic [`RV_XLEN-1:0]   wb_result_i,
    output logic                  ex_valid_o,
    output logic [`RV_XLEN-1:0]   ex_pc_o,
    output logic [`RV_XLEN-1:0]   ex_a_o,
    output logic [`RV_XLEN-1:0]   ex_b_o,
    output logic [`RV_XLEN-1:0]   ex_imm_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_use_imm_o,
    output logic [`RV_REG_AW-1:0] ex_rd_o,
    output logic                  ex_rd_en_o,
    output br_kind_e              ex_br_kind_o
);

    fwd_sel_e            sel_a;
    fwd_sel_e            sel_b;
    logic [`RV_XLEN-1:0] opnd_a;
    logic [`RV_XLEN-1:0] opnd_b;

    // youngest producer wins
    function automatic fwd_sel_e pick_src(input logic [`RV_REG_AW-1:0] idx);
        if (idx != '0 && ex_rd_en_i && idx == ex_rd_i)
            return FWD_EX;
        if (idx != '0 && wb_rd_en_i && idx == wb_rd_i)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic logic [`RV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                    input logic [`RV_XLEN-1:0] reg_data);
        case (sel)
            FWD_EX:  return ex_result_i;
            FWD_WB:  return wb_result_i;
            default: return reg_data;
        endcase
    endfunction

    always_comb begin
        sel_a  = pick_src(rs1_i);
        sel_b  = pick_src(rs2_i);
        opnd_a = fwd_mux(sel_a, rs1_data_i);
        opnd_b = fwd_mux(sel_b, rs2_data_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_rd_en_o   <= 1'b0;
            ex_br_kind_o <= BR_NONE;
        end else begin
            ex_valid_o   <= id_valid_i && !flush_i;   // shadow of a taken transfer
            ex_rd_en_o   <= rd_en_i;
            ex_br_kind_o <= br_kind_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o      <= id_pc_i;
        ex_a_o       <= opnd_a;
        ex_b_o       <= opnd_b;
        ex_imm_o     <= imm_i;
        ex_alu_op_o  <= alu_op_i;
        ex_use_imm_o <= use_imm_i;
        ex_rd_o      <= rd_i;
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    input  logic                  we_i,
    input  logic [`RV_REG_AW-1:0] wd_idx_i,
    input  logic [`RV_XLEN-1:0]   wd_data_i
);

    logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

    // x0 reads zero, a write in flight is seen at once
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        if (we_i && idx == wd_idx_i)
            return wd_data_i;
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wd_idx_i != '0) begin
            regs_q[wd_idx_i] <= wd_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32               // data path width
`define RV_NREGS     32               // architectural registers
`define RV_REG_AW    5                // register index width
`define RV_RESET_PC  32'h0000_0000    // first fetch address
`define RV_ILEN      32               // instruction word width

`endif

// ==== rv_core_checker.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_checker (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic [`RV_XLEN-1:0]   pc_i,
    input logic                  wb_valid_i,
    input logic [`RV_REG_AW-1:0] wb_rd_i
);

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    a_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i |-> wb_rd_i != '0)
        else $error("retirement reported for register x0");

    // no retirement may leak out while the core is held in reset
    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !wb_valid_i)
        else $error("wb_valid_o high during reset");

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_top import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`RV_ILEN-1:0]   inst_i,
    output logic [`RV_XLEN-1:0]   pc_o,
    output logic                  wb_valid_o,
    output logic [`RV_REG_AW-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]   wb_data_o
);

    // fetch to decode
    logic                  redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;
    inst_u                 id_inst;
    logic [`RV_XLEN-1:0]   id_pc;
    logic                  id_valid;
    // decode outputs
    logic [`RV_REG_AW-1:0] id_rs1;
    logic [`RV_REG_AW-1:0] id_rs2;
    logic [`RV_REG_AW-1:0] id_rd;
    logic [`RV_XLEN-1:0]   id_imm;
    alu_op_e               id_alu_op;
    logic                  id_use_imm;
    logic                  id_rd_en;
    br_kind_e              id_br_kind;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    // execute stage
    logic                  ex_valid;
    logic [`RV_XLEN-1:0]   ex_pc;
    logic [`RV_XLEN-1:0]   ex_a;
    logic [`RV_XLEN-1:0]   ex_b;
    logic [`RV_XLEN-1:0]   ex_imm;
    alu_op_e               ex_alu_op;
    logic                  ex_use_imm;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic                  ex_rd_en;
    br_kind_e              ex_br_kind;
    logic [`RV_XLEN-1:0]   ex_result;
    logic                  ex_fwd_en;

    fetch_unit u_fetch_unit (
        .clk           (clk         ),
        .rst_n_i       (rst_n_i     ),
        .redirect_i    (redirect    ),
        .redirect_pc_i (redirect_pc ),
        .inst_i        (inst_i      ),
        .pc_o          (pc_o        ),
        .id_inst_o     (id_inst     ),
        .id_pc_o       (id_pc       ),
        .id_valid_o    (id_valid    )
    );

    inst_decoder u_inst_decoder (
        .inst_i        (id_inst     ),
        .rs1_o         (id_rs1      ),
        .rs2_o         (id_rs2      ),
        .rd_o          (id_rd       ),
        .imm_o         (id_imm      ),
        .alu_op_o      (id_alu_op   ),
        .use_imm_o     (id_use_imm  ),
        .rd_en_o       (id_rd_en    ),
        .br_kind_o     (id_br_kind  )
    );

    regfile u_regfile (
        .clk           (clk         ),
        .rst_n_i       (rst_n_i     ),
        .rs1_i         (id_rs1      ),
        .rs2_i         (id_rs2      ),
        .rs1_data_o    (rs1_data    ),
        .rs2_data_o    (rs2_data    ),
        .we_i          (wb_valid_o  ),
        .wd_idx_i      (wb_rd_o     ),
        .wd_data_i     (wb_data_o   )
    );

    issue_stage u_issue_stage (
        .clk           (clk         ),
        .rst_n_i       (rst_n_i     ),
        .id_valid_i    (id_valid    ),
        .id_pc_i       (id_pc       ),
        .rs1_i         (id_rs1      ),
        .rs2_i         (id_rs2      ),
        .rs1_data_i    (rs1_data    ),
        .rs2_data_i    (rs2_data    ),
        .imm_i         (id_imm      ),
        .alu_op_i      (id_alu_op   ),
        .use_imm_i     (id_use_imm  ),
        .rd_i          (id_rd       ),
        .rd_en_i       (id_rd_en    ),
        .br_kind_i     (id_br_kind  ),
        .flush_i       (redirect    ),
        .ex_rd_i       (ex_rd       ),
        .ex_rd_en_i    (ex_fwd_en   ),
        .ex_result_i   (ex_result   ),
        .wb_rd_i       (wb_rd_o     ),
        .wb_rd_en_i    (wb_valid_o  ),
        .wb_result_i   (wb_data_o   ),
        .ex_valid_o    (ex_valid    ),
        .ex_pc_o       (ex_pc       ),
        .ex_a_o        (ex_a        ),
        .ex_b_o        (ex_b        ),
        .ex_imm_o      (ex_imm      ),
        .ex_alu_op_o   (ex_alu_op   ),
        .ex_use_imm_o  (ex_use_imm  ),
        .ex_rd_o       (ex_rd       ),
        .ex_rd_en_o    (ex_rd_en    ),
        .ex_br_kind_o  (ex_br_kind  )
    );

    exec_unit u_exec_unit (
        .clk           (clk         ),
        .rst_n_i       (rst_n_i     ),
        .ex_valid_i    (ex_valid    ),
        .ex_pc_i       (ex_pc       ),
        .ex_a_i        (ex_a        ),
        .ex_b_i        (ex_b        ),
        .ex_imm_i      (ex_imm      ),
        .ex_alu_op_i   (ex_alu_op   ),
        .ex_use_imm_i  (ex_use_imm  ),
        .ex_rd_i       (ex_rd       ),
        .ex_rd_en_i    (ex_rd_en    ),
        .ex_br_kind_i  (ex_br_kind  ),
        .redirect_o    (redirect    ),
        .redirect_pc_o (redirect_pc ),
        .ex_result_o   (ex_result   ),
        .ex_fwd_en_o   (ex_fwd_en   ),
        .wb_valid_o    (wb_valid_o  ),
        .wb_rd_o       (wb_rd_o     ),
        .wb_result_o   (wb_data_o   )
    );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module tb_rv_core;

    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 200;          // cycles per program
    localparam int DRAIN_CYCLES = 12;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic [`RV_ILEN-1:0]   inst_i;
    logic [`RV_XLEN-1:0]   pc_o;
    logic                  wb_valid_o;
    logic [`RV_REG_AW-1:0] wb_rd_o;
    logic [`RV_XLEN-1:0]   wb_data_o;

    logic [`RV_ILEN-1:0]   mem [64];
    logic [`RV_REG_AW-1:0] exp_rd_q [$];
    logic [`RV_XLEN-1:0]   exp_val_q [$];
    logic [31:0]           lcg_state = 32'h6e43_e5d2;
    int                    prog_len;
    int                    ret_idx;
    int                    since_reset;
    int                    errors;
    int                    err_base;
    int                    tests_run;
    int                    tests_failed;

    always #4 clk = ~clk;

    assign inst_i = mem[pc_o[7:2]];             // rom answers in the same cycle

    rv_core_top dut_i (
        .clk        (clk       ),
        .rst_n_i    (rst_n_i   ),
        .inst_i     (inst_i    ),
        .pc_o       (pc_o      ),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o   ),
        .wb_data_o  (wb_data_o )
    );

    bind rv_core_top rv_core_checker u_checker (
        .clk        (clk       ),
        .rst_n_i    (rst_n_i   ),
        .pc_i       (pc_o      ),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o   )
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[6'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 64; i++) begin
            mem[6'(i)] = alu_imm(12'(i * 4), 5'd0, 3'd0, 5'd0);    // addi x0 tagged by address
        end
    endtask

    // architectural model that runs the program to its self loop and lists the retirements
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr;
        logic        stop;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        exp_rd_q.delete();
        exp_val_q.delete();
        pc    = `RV_RESET_PC;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 512) begin
            w       = mem[pc[7:2]];
            rd      = w[11:7];
            f3      = w[14:12];
            f7      = w[31:25];
            a       = x[w[19:15]];
            b       = x[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (w[6:0])
                7'b0110011: begin
                    if (f7 == 7'h20 && f3 == 3'd0) begin
                        res = a - b;
                    end else if (f7 != 7'h00) begin
                        wr = 1'b0;
                    end else begin
                        case (f3)
                            3'd0:    res = a + b;
                            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            3'd4:    res = a ^ b;
                            3'd6:    res = a | b;
                            3'd7:    res = a & b;
                            default: wr = 1'b0;
                        endcase
                    end
                end
                7'b0010011: begin
                    case (f3)
                        3'd0:    res = a + imm_i;
                        3'd4:    res = a ^ imm_i;
                        3'd6:    res = a | imm_i;
                        3'd7:    res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b))
                        next_pc = pc + imm_b;
                end
                7'b1101111: begin
                    res     = pc + 32'd4;                  // link value
                    next_pc = pc + imm_j;
                    stop    = (rd == 5'd0 && imm_j == 32'd0);
                end
                default: wr = 1'b0;
            endcase
            if (!stop && wr && rd != 5'd0) begin
                x[rd] = res;
                exp_rd_q.push_back(rd);
                exp_val_q.push_back(res);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // retire port monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n_i) begin
            ret_idx     = 0;
            since_reset = 0;
            check_value("pc_o during reset", pc_o, `RV_RESET_PC);
            check_value("wb_valid_o during reset", 32'(wb_valid_o), 32'd0);
        end else begin
            since_reset++;
            if (since_reset == 1)
                check_value("pc_o after reset release", pc_o, `RV_RESET_PC);
            if (wb_valid_o) begin
                check_value("retirement before pipeline fill", 32'(since_reset < 4), 32'd0);
                if (ret_idx < exp_rd_q.size()) begin
                    check_value($sformatf("retirement %0d rd", ret_idx), 32'(wb_rd_o),
                                32'(exp_rd_q[ret_idx]));
                    check_value($sformatf("retirement %0d data", ret_idx), wb_data_o,
                                exp_val_q[ret_idx]);
                end else begin
                    $display("unexpected retirement of x%0d at %0d ns, past the end of the program",
                             wb_rd_o, $time);
                    errors++;
                end
                ret_idx++;
            end
        end
    end

    task automatic begin_program();
        err_base = errors;
        @(posedge clk);
        rst_n_i <= 1'b0;
        @(posedge clk);
        fill_memory();                          // core is held in reset here
        prog_len = 0;
    endtask

    task automatic run_program(input string name);
        int waited;
        emit(jal_word(21'd0, 5'd0));            // self loop ends every program
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge clk);
        end
        run_reference();
        rst_n_i <= 1'b1;
        waited  = 0;
        while (ret_idx < exp_rd_q.size() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (ret_idx < exp_rd_q.size()) begin
            $display("timeout: %s retired %0d of %0d instructions within %0d cycles",
                     name, ret_idx, exp_rd_q.size(), WAIT_LIMIT);
            errors++;
        end
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(posedge clk);                     // stray retirements show up here
        end
        tests_run++;
        if (errors != err_base)
            tests_failed++;
        $display("test %0d %s: %s, %0d retirements", tests_run, name,
                 (errors == err_base) ? "ok" : "failed", ret_idx);
    endtask

    initial begin
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        rst_n_i = 1'b0;
        fill_memory();

        begin_program();
        emit(alu_imm(12'd5, 5'd0, 3'd0, 5'd1));
        run_program("reset");

        begin_program();
        for (int k = 0; k < 32; k++) begin
            r   = lcg_next();
            rd  = {2'b00, r[6:4]};              // x0 now and then
            rs1 = {2'b00, r[9:7]};
            rs2 = {2'b00, r[12:10]};
            case (r[31:28])
                4'd1:    emit(alu_imm(r[24:13], rs1, 3'd7, rd));
                4'd2:    emit(alu_imm(r[24:13], rs1, 3'd6, rd));
                4'd3:    emit(alu_imm(r[24:13], rs1, 3'd4, rd));
                4'd4:    emit(alu_rr(7'h00, rs2, rs1, 3'd0, rd));
                4'd5:    emit(alu_rr(7'h20, rs2, rs1, 3'd0, rd));
                4'd6:    emit(alu_rr(7'h00, rs2, rs1, 3'd7, rd));
                4'd7:    emit(alu_rr(7'h00, rs2, rs1, 3'd6, rd));
                4'd8:    emit(alu_rr(7'h00, rs2, rs1, 3'd4, rd));
                4'd9:    emit(alu_rr(7'h00, rs2, rs1, 3'd2, rd));
                default: emit(alu_imm(r[24:13], rs1, 3'd0, rd));
            endcase
        end
        run_program("random alu");

        begin_program();
        r = lcg_next();
        emit(alu_imm(r[11:0], 5'd0, 3'd0, 5'd1));
        emit(alu_rr(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));        // distance one on both operands
        emit(alu_imm(r[23:12], 5'd0, 3'd0, 5'd3));
        r = lcg_next();
        emit(alu_imm(r[11:0], 5'd0, 3'd0, 5'd4));
        emit(alu_rr(7'h20, 5'd4, 5'd3, 3'd0, 5'd5));        // distances two and one
        emit(alu_imm(r[23:12], 5'd0, 3'd0, 5'd6));
        r = lcg_next();
        emit(alu_imm(r[11:0], 5'd0, 3'd0, 5'd7));
        emit(alu_imm(r[23:12], 5'd0, 3'd0, 5'd8));
        emit(alu_rr(7'h00, 5'd8, 5'd6, 3'd4, 5'd9));        // x6 at distance three
        emit(alu_rr(7'h00, 5'd2, 5'd7, 3'd6, 5'd10));
        emit(alu_rr(7'h00, 5'd9, 5'd10, 3'd2, 5'd11));
        emit(alu_imm(12'd1, 5'd11, 3'd0, 5'd12));
        emit(alu_imm(12'd1, 5'd12, 3'd0, 5'd12));
        run_program("dependencies");

        begin_program();
        emit(alu_imm(12'd3, 5'd0, 3'd0, 5'd1));
        emit(alu_imm(12'd3, 5'd0, 3'd0, 5'd2));
        emit(branch_word(13'd12, 5'd2, 5'd1, 3'd0));        // beq taken
        emit(alu_imm(12'd1, 5'd0, 3'd0, 5'd3));
        emit(alu_imm(12'd2, 5'd0, 3'd0, 5'd4));
        emit(alu_imm(12'd5, 5'd0, 3'd0, 5'd5));
        emit(branch_word(13'd8, 5'd2, 5'd1, 3'd1));         // bne not taken
        emit(alu_imm(12'd6, 5'd0, 3'd0, 5'd6));
        emit(alu_imm(12'd7, 5'd0, 3'd0, 5'd7));
        emit(branch_word(13'd16, 5'd1, 5'd7, 3'd1));        // bne taken on forwarded x7
        emit(alu_imm(12'd8, 5'd0, 3'd0, 5'd8));
        emit(alu_imm(12'd9, 5'd0, 3'd0, 5'd9));
        emit(alu_imm(12'd10, 5'd0, 3'd0, 5'd10));
        emit(alu_imm(12'd11, 5'd0, 3'd0, 5'd11));
        emit(branch_word(13'd8, 5'd7, 5'd1, 3'd0));         // beq not taken
        emit(alu_imm(12'd12, 5'd0, 3'd0, 5'd12));
        emit(alu_imm(12'd3, 5'd0, 3'd0, 5'd13));
        emit(alu_imm(12'hfff, 5'd13, 3'd0, 5'd13));         // countdown loop
        emit(branch_word(13'h1ffc, 5'd0, 5'd13, 3'd1));
        run_program("branches");

        begin_program();
        emit(alu_imm(12'd1, 5'd0, 3'd0, 5'd1));
        emit(jal_word(21'd12, 5'd5));
        emit(alu_imm(12'd2, 5'd0, 3'd0, 5'd2));
        emit(alu_imm(12'd3, 5'd0, 3'd0, 5'd3));
        emit(alu_imm(12'd0, 5'd5, 3'd0, 5'd4));             // first target reads the link
        emit(jal_word(21'd8, 5'd6));
        emit(alu_imm(12'd7, 5'd0, 3'd0, 5'd7));
        emit(alu_rr(7'h00, 5'd6, 5'd5, 3'd0, 5'd8));
        run_program("jal");

        begin_program();
        emit(alu_imm(12'h123, 5'd0, 3'd0, 5'd0));
        emit(alu_imm(12'h7ff, 5'd0, 3'd0, 5'd1));
        emit(alu_rr(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        emit(alu_rr(7'h00, 5'd0, 5'd0, 3'd6, 5'd2));        // x0 read right after a write
        emit(alu_imm(12'hfff, 5'd0, 3'd4, 5'd3));
        emit(jal_word(21'd8, 5'd0));
        emit(alu_imm(12'd9, 5'd0, 3'd0, 5'd4));
        emit(alu_rr(7'h00, 5'd0, 5'd3, 3'd0, 5'd5));
        run_program("x0 writes");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
fetch_unit.sv
inst_decoder.sv
regfile.sv
issue_stage.sv
exec_unit.sv
rv_core_top.sv
rv_core_checker.sv
tb_rv_core.sv
